/* compile.f */
source/decode_pkg.sv
source/field_selector.sv
source/ucontrol_store.sv
source/operand_decode.sv
source/stage_register.sv
source/decode_stage2.sv
dv/decode_checker.sv
dv/decode_stage2_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the stage-2 decode testbench with verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log
BUILD=obj_dir

verilator --binary --timing --assert -Wno-fatal -j 0 \
   --top-module decode_stage2_tb --Mdir "$BUILD" -f compile.f
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

"./$BUILD/Vdecode_stage2_tb" | tee "$LOG"
if [ "${PIPESTATUS[0]}" -ne 0 ]; then
   echo "simulation exited with an error"
   exit 1
fi

if grep -q "STATUS: FAIL" "$LOG"; then
   echo "simulation reported failure, see $LOG"
   exit 1
fi
exit 0

/* dv/decode_stage2_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module decode_stage2_tb;

   localparam int max_rows       = 10;
   localparam int passes         = 3;
   localparam int timeout_cycles = 200;

   logic                   clk;
   logic                   arst_n;
   logic                   in_valid;
   decode_pkg::d1_packet_t in_pkt;
   logic                   in_ready;
   logic                   out_valid;
   decode_pkg::d2_packet_t out_pkt;
   logic                   out_ready;
   logic [31:0]            rnd;

   string                  row_name [max_rows];
   decode_pkg::d1_packet_t row_in [max_rows];
   decode_pkg::d2_packet_t row_exp [max_rows];
   int                     nrows = 0;
   int                     tb_errors = 0;
   bit                     timed_out = 1'b0;

   decode_stage2 dut_i (
      .clk       (clk),
      .arst_n    (arst_n),
      .in_valid  (in_valid),
      .in_pkt    (in_pkt),
      .in_ready  (in_ready),
      .out_valid (out_valid),
      .out_pkt   (out_pkt),
      .out_ready (out_ready)
   );

   decode_checker chk_i (
      .clk       (clk),
      .arst_n    (arst_n),
      .in_ready  (in_ready),
      .out_valid (out_valid),
      .out_ready (out_ready),
      .out_pkt   (out_pkt)
   );

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      return y ^ (y << 5);
   endfunction

   // eip and cs pass straight through and illegal mirrors the controls
   task automatic add_row(input string name, input decode_pkg::d1_packet_t d1,
                          input decode_pkg::ag_ctrl_t ctl, input logic [31:0] imm,
                          input logic [31:0] disp, input logic [47:0] offset);
      decode_pkg::d1_packet_t d1_row;
      d1_row            = d1;
      d1_row.eip        = 32'h0040_1000 + (nrows << 4);
      d1_row.cs         = 16'h001B;
      row_name[nrows]   = name;
      row_in[nrows]     = d1_row;
      row_exp[nrows]    = '{eip: d1_row.eip, cs: d1_row.cs, ctrl: ctl, imm32: imm,
                            disp32: disp, offset48: offset, illegal: ctl.illegal};
      nrows++;
   endtask

   task automatic build_table();
      decode_pkg::d1_packet_t d1;
      decode_pkg::ag_ctrl_t   ctl;
      // 89 /r register form with modrm d9 (mod 3 reg 3 rm 1)
      d1  = '{opcode: 16'h0089, ir: 128'hD989, modrm_present: 1'b1, modrm_sel: 4'd1,
              default: '0};
      ctl = '{data_size: 2'd2, ld_gpr1: 1'b1, aluk: 3'd5, base: 3'd1, sr1: 3'd1, sr2: 3'd3,
              seg1: 3'd3, seg2: 3'd2, default: '0};
      add_row("mov_rm_reg", d1, ctl, 32'h0, 32'h0, 48'h0);
      // memory form with disp8 f0 that the modrm selector also reads as its sib byte
      d1  = '{opcode: 16'h0089, ir: 128'hF01389, modrm_present: 1'b1, modrm_sel: 4'd1,
              disp_present: 1'b1, disp_sel: 4'd2, disp_size: 2'd0, default: '0};
      ctl = '{data_size: 2'd2, seg1_needed: 1'b1, mem_rd: 1'b1, mem_wr: 1'b1, aluk: 3'd5,
              base: 3'd3, sr1: 3'd3, sr2: 3'd2, seg1: 3'd3, seg2: 3'd2, disp_en: 1'b1,
              sib_scale: 2'd3, index: 3'd6, default: '0};
      add_row("mov_rm_mem_disp8", d1, ctl, 32'h0, 32'hFFFF_FFF0, 48'h0);
      // 81 /1 with sib af (scale 2 index 5 base 7) and imm32 under a 66 prefix
      d1  = '{opcode: 16'h0081, ir: 128'h1234_5678_AF0C_81, operand_override: 1'b1,
              modrm_present: 1'b1, modrm_sel: 4'd1, sib_present: 1'b1, imm_present: 1'b1,
              imm_sel: 4'd3, imm_size: 2'd2, default: '0};
      ctl = '{data_size: 2'd1, seg1_needed: 1'b1, mem_rd: 1'b1, mem_wr: 1'b1, aluk: 3'd1,
              sr1_needed: 1'b1, base: 3'd7, sr1: 3'd7, sr2: 3'd1, seg1: 3'd3, seg2: 3'd2,
              sib_en: 1'b1, sib_scale: 2'd2, index: 3'd5, default: '0};
      add_row("grp1_or_sib_imm32", d1, ctl, 32'h1234_5678, 32'h0, 48'h0);
      d1  = '{opcode: 16'h0F7F, opcode_size: 1'b1, ir: 128'hD57F0F, modrm_present: 1'b1,
              modrm_sel: 4'd2, default: '0};
      ctl = '{data_size: 2'd3, ld_mm: 1'b1, base: 3'd5, sr1: 3'd5, sr2: 3'd2, seg1: 3'd3,
              seg2: 3'd2, default: '0};
      add_row("movq_store_reg", d1, ctl, 32'h0, 32'h0, 48'h0);
      d1  = '{opcode: 16'h0F7F, opcode_size: 1'b1, ir: 128'h167F0F, modrm_present: 1'b1,
              modrm_sel: 4'd2, default: '0};
      ctl = '{data_size: 2'd3, seg1_needed: 1'b1, mem_wr: 1'b1, sr1_needed: 1'b1, base: 3'd6,
              sr1: 3'd6, sr2: 3'd2, seg1: 3'd3, seg2: 3'd2, default: '0};
      add_row("movq_store_mem", d1, ctl, 32'h0, 32'h0, 48'h0);
      d1  = '{opcode: 16'h0F6F, opcode_size: 1'b1, ir: 128'hCC6F0F, modrm_present: 1'b1,
              modrm_sel: 4'd2, default: '0};
      ctl = '{data_size: 2'd3, mm1_needed: 1'b1, ld_mm: 1'b1, base: 3'd4, sr1: 3'd4,
              sr2: 3'd1, seg1: 3'd3, seg2: 3'd2, default: '0};
      add_row("movq_load_reg", d1, ctl, 32'h0, 32'h0, 48'h0);
      d1  = '{opcode: 16'h0FB1, opcode_size: 1'b1, ir: 128'h18B10F, modrm_present: 1'b1,
              modrm_sel: 4'd2, default: '0};
      ctl = '{data_size: 2'd2, seg1_needed: 1'b1, mem_rd: 1'b1, mem_wr: 1'b1, aluk: 3'd7,
              sr1_needed: 1'b1, sr2: 3'd3, seg1: 3'd3, seg2: 3'd2, cmpxchg: 1'b1,
              default: '0};
      add_row("cmpxchg_mem", d1, ctl, 32'h0, 32'h0, 48'h0);
      d1  = '{opcode: 16'h00D6, ir: 128'hD6, default: '0};
      ctl = '{seg1: 3'd3, seg2: 3'd2, illegal: 1'b1, default: '0};
      add_row("illegal_d6", d1, ctl, 32'h0, 32'h0, 48'h0);
      // add eax,imm32 with a segment override to segment 4
      d1  = '{opcode: 16'h0005, ir: 128'hDEAD_BEEF_05, segment_override: 1'b1, seg_id: 3'd4,
              imm_present: 1'b1, imm_sel: 4'd1, imm_size: 2'd2, default: '0};
      ctl = '{data_size: 2'd2, ld_gpr1: 1'b1, sr1_needed: 1'b1, seg1: 3'd4, seg2: 3'd2,
              default: '0};
      add_row("seg_override_add", d1, ctl, 32'hDEAD_BEEF, 32'h0, 48'h0);
      // far pointer in bytes 1 to 6 with byte 7 left out
      d1  = '{opcode: 16'h00EA, ir: 128'h7766_5544_3322_11EA, offset_present: 1'b1,
              offset_sel: 4'd1, offset_size: 2'd3, default: '0};
      ctl = '{seg1: 3'd3, seg2: 3'd2, illegal: 1'b1, default: '0};
      add_row("far_jmp_offset48", d1, ctl, 32'h0, 32'h0, 48'h6655_4433_2211);
   endtask

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   // random back-pressure with about one stall in four cycles
   initial begin
      rnd       = 32'habb9e8ed;
      out_ready = 1'b0;
      forever begin
         @(negedge clk);
         rnd       = xorshift32(rnd);
         out_ready = (rnd[1:0] != 2'b00);
      end
   end

   initial begin
      decode_pkg::d1_packet_t pkt;
      decode_pkg::d2_packet_t exp_pkt;
      int                     timer;
      arst_n   = 1'b0;
      in_valid = 1'b0;
      in_pkt   = '0;
      build_table();
      repeat (10) @(negedge clk);
      arst_n = 1'b1;
      for (int p = 0; p < passes; p++) begin
         for (int i = 0; i < nrows; i++) begin
            pkt         = row_in[i];
            pkt.eip     = pkt.eip + (p << 24);
            exp_pkt     = row_exp[i];
            exp_pkt.eip = pkt.eip;
            @(negedge clk);
            in_valid = 1'b1;
            in_pkt   = pkt;
            // in_ready is settled a quarter period after the falling edge
            #10;
            timer = 0;
            while (!in_ready && timer < timeout_cycles) begin
               @(negedge clk);
               #10;
               timer++;
            end
            if (!in_ready) begin
               $display("timeout: row %s was not accepted within %0d cycles",
                        row_name[i], timeout_cycles);
               timed_out = 1'b1;
               break;
            end
            chk_i.expect_packet(row_name[i], exp_pkt);
         end
         if (timed_out) begin
            break;
         end
      end
      @(negedge clk);
      in_valid = 1'b0;
      timer    = 0;
      while (!timed_out && chk_i.pending_count() != 0 && timer < timeout_cycles) begin
         @(negedge clk);
         timer++;
      end
      if (chk_i.pending_count() != 0) begin
         $display("timeout: %0d expected packets never left the stage",
                  chk_i.pending_count());
         tb_errors++;
      end
      // a few idle cycles so a repeated packet would still show up
      repeat (5) @(negedge clk);
      $display("tests: %0d passed, %0d failed, %0d other errors", chk_i.pass_count,
               chk_i.fail_count, tb_errors + int'(timed_out));
      // every row of every pass plus the reset state
      if (!timed_out && tb_errors == 0 && chk_i.fail_count == 0 &&
          chk_i.pass_count == passes * nrows + 1) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* dv/decode_checker.sv */
`timescale 1ns/100ps
`default_nettype none

module decode_checker (
   input logic                   clk,
   input logic                   arst_n,
   input logic                   in_ready,
   input logic                   out_valid,
   input logic                   out_ready,
   input decode_pkg::d2_packet_t out_pkt
);

   // expected packets in acceptance order with the row name beside each
   string                  name_q [$];
   decode_pkg::d2_packet_t exp_q [$];
   string                  cur_name;
   decode_pkg::d2_packet_t cur_exp;
   bit                     reset_checked = 1'b0;
   int                     pass_count = 0;
   int                     fail_count = 0;

   task automatic expect_packet(input string name, input decode_pkg::d2_packet_t pkt);
      name_q.push_back(name);
      exp_q.push_back(pkt);
   endtask

   function automatic int pending_count();
      return exp_q.size();
   endfunction

   // on the first rising edge out of reset the stage is empty and ready
   always @(posedge clk) begin
      if (arst_n && !reset_checked) begin
         reset_checked = 1'b1;
         if (out_valid !== 1'b0 || in_ready !== 1'b1) begin
            $display("Error: reset_state expected valid 0 ready 1, actual valid %b ready %b",
                     out_valid, in_ready);
            fail_count++;
         end else begin
            $display("ok    reset_state");
            pass_count++;
         end
      end
   end

   // an output transfer is valid and ready at the rising edge
   always @(posedge clk) begin
      if (arst_n && out_valid && out_ready) begin
         if (exp_q.size() == 0) begin
            $display("output packet with eip %h arrived with no expected packet queued",
                     out_pkt.eip);
            fail_count++;
         end else begin
            cur_name = name_q.pop_front();
            cur_exp  = exp_q.pop_front();
            if (out_pkt !== cur_exp) begin
               $display("Error: %s expected %h actual %h", cur_name, cur_exp, out_pkt);
               fail_count++;
            end else begin
               $display("ok    %s (eip %h)", cur_name, out_pkt.eip);
               pass_count++;
            end
         end
      end
   end

endmodule

`default_nettype wire

/* source/decode_stage2.sv */
`timescale 1ns/100ps
`default_nettype none

module decode_stage2 (
   input  logic                   clk,
   input  logic                   arst_n,
   input  logic                   in_valid,
   input  decode_pkg::d1_packet_t in_pkt,
   output logic                   in_ready,
   output logic                   out_valid,
   output decode_pkg::d2_packet_t out_pkt,
   input  logic                   out_ready
);

   decode_pkg::modrm_sib_t  ms;
   decode_pkg::ucode_word_t uword;
   decode_pkg::ag_ctrl_t    ctrl;
   decode_pkg::d2_packet_t  d2_pkt;
   logic [31:0]             disp32;
   logic [31:0]             imm32;
   logic [47:0]             offset48;

   // modrm and sib are read as one 2-byte field
   field_selector #(
      .payload_t (decode_pkg::modrm_sib_t),
      .SIGNED    (1'b0)
   ) modrm_sib_sel_i (
      .ir      (in_pkt.ir),
      .sel     (in_pkt.modrm_sel),
      .size    (decode_pkg::size_word),
      .present (in_pkt.modrm_present),
      .field   (ms)
   );

   // displacement is sign-extended to 32 bits
   field_selector #(
      .payload_t (logic [31:0]),
      .SIGNED    (1'b1)
   ) disp_sel_i (
      .ir      (in_pkt.ir),
      .sel     (in_pkt.disp_sel),
      .size    (in_pkt.disp_size),
      .present (in_pkt.disp_present),
      .field   (disp32)
   );

   field_selector #(
      .payload_t (logic [31:0]),
      .SIGNED    (1'b0)
   ) imm_sel_i (
      .ir      (in_pkt.ir),
      .sel     (in_pkt.imm_sel),
      .size    (in_pkt.imm_size),
      .present (in_pkt.imm_present),
      .field   (imm32)
   );

   // far pointer, offset plus selector
   field_selector #(
      .payload_t (logic [47:0]),
      .SIGNED    (1'b0)
   ) offset_sel_i (
      .ir      (in_pkt.ir),
      .sel     (in_pkt.offset_sel),
      .size    (in_pkt.offset_size),
      .present (in_pkt.offset_present),
      .field   (offset48)
   );

   ucontrol_store ucontrol_store_i (
      .opcode   (in_pkt.opcode[7:0]),
      .two_byte (in_pkt.opcode_size),
      .word     (uword)
   );

   operand_decode operand_decode_i (
      .modrm_present    (in_pkt.modrm_present),
      .sib_present      (in_pkt.sib_present),
      .disp_present     (in_pkt.disp_present),
      .operand_override (in_pkt.operand_override),
      .segment_override (in_pkt.segment_override),
      .seg_id           (in_pkt.seg_id),
      .opcode           (in_pkt.opcode),
      .word             (uword),
      .ms               (ms),
      .ctrl             (ctrl)
   );

   always_comb begin
      d2_pkt.eip      = in_pkt.eip;
      d2_pkt.cs       = in_pkt.cs;
      d2_pkt.ctrl     = ctrl;
      d2_pkt.imm32    = imm32;
      d2_pkt.disp32   = disp32;
      d2_pkt.offset48 = offset48;
      d2_pkt.illegal  = ctrl.illegal;
   end

   stage_register stage_register_i (
      .clk       (clk),
      .arst_n    (arst_n),
      .in_valid  (in_valid),
      .in_pkt    (d2_pkt),
      .in_ready  (in_ready),
      .out_valid (out_valid),
      .out_pkt   (out_pkt),
      .out_ready (out_ready)
   );

endmodule

`default_nettype wire

/* source/stage_register.sv */
`timescale 1ns/100ps
`default_nettype none

module stage_register (
   input  logic                   clk,
   input  logic                   arst_n,
   input  logic                   in_valid,
   input  decode_pkg::d2_packet_t in_pkt,
   output logic                   in_ready,
   output logic                   out_valid,
   output decode_pkg::d2_packet_t out_pkt,
   input  logic                   out_ready
);

   logic                   full;
   decode_pkg::d2_packet_t data;

   // accept when empty, or when the held packet leaves this cycle
   assign in_ready  = !full || out_ready;
   assign out_valid = full;
   assign out_pkt   = data;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         full <= 1'b0;
      end else if (in_ready) begin
         full <= in_valid;
      end
   end

   always_ff @(posedge clk) begin
      if (in_valid && in_ready) begin
         data <= in_pkt;
      end
   end

   // a stalled packet stays put until the consumer takes it
   a_stall_hold: assert property (
      @(posedge clk) disable iff (!arst_n)
      out_valid && !out_ready |=> out_valid && $stable(out_pkt)
   ) else $error("stage_register: output changed while stalled");

endmodule

`default_nettype wire

/* source/operand_decode.sv */
`timescale 1ns/100ps
`default_nettype none

module operand_decode (
   input  logic                    modrm_present,
   input  logic                    sib_present,
   input  logic                    disp_present,
   input  logic                    operand_override,
   input  logic                    segment_override,
   input  logic [2:0]              seg_id,
   input  logic [15:0]             opcode,
   input  decode_pkg::ucode_word_t word,
   input  decode_pkg::modrm_sib_t  ms,
   output decode_pkg::ag_ctrl_t    ctrl
);

   logic       mem_form;
   logic       reg_form;
   logic       op_0f7f;
   logic       op_cmpxchg;
   logic [2:0] base_id;

   always_comb begin
      mem_form   = modrm_present && (ms.mod != 2'b11);
      reg_form   = modrm_present && (ms.mod == 2'b11);
      op_0f7f    = (opcode == 16'h0F7F);
      // 0FB0 and 0FB1 differ only in bit 0
      op_cmpxchg = ({opcode[15:1], 1'b0} == 16'h0FB0);
      base_id    = sib_present ? ms.base : ms.rm;
   end

   always_comb begin
      if (operand_override) begin
         ctrl.data_size = 2'd1;
      end else begin
         ctrl.data_size = word.data_size;
      end

      // bits the word can hand over to the mod field
      ctrl.seg1_needed = word.mux_seg1_needed ? mem_form : word.seg1_needed;
      ctrl.mem_rd      = word.mux_mem_rd ? mem_form : word.mem_rd;
      ctrl.mem_wr      = word.mux_mem_wr ? mem_form : word.mem_wr;
      ctrl.ld_gpr1     = word.mux_ld_gpr1 ? reg_form : word.ld_gpr1;
      ctrl.aluk        = word.mux_aluk ? ms.reg_op : word.aluk;

      // register ids, sr1 defaults to the base register
      ctrl.base = base_id;
      ctrl.sr1  = word.mux_sr1 ? word.sr1 : base_id;
      ctrl.sr2  = word.mux_sr2 ? word.sr2 : ms.reg_op;

      if (segment_override) begin
         ctrl.seg1 = seg_id;
      end else begin
         ctrl.seg1 = decode_pkg::seg_ds;
      end
      if (word.mux_seg2) begin
         ctrl.seg2 = ms.reg_op;
      end else begin
         ctrl.seg2 = decode_pkg::seg_ss;
      end

      // movq mm/m64,mm in register form writes the destination mm
      ctrl.ld_mm      = word.ld_mm || (reg_form && op_0f7f);
      // mmx memory forms read the address base from a gpr
      ctrl.sr1_needed = word.sr1_needed || (word.mm1_needed && mem_form);
      ctrl.mm1_needed = word.mm1_needed && reg_form && !op_0f7f;

      ctrl.cmpxchg   = op_cmpxchg;
      ctrl.sib_en    = sib_present;
      ctrl.disp_en   = disp_present;
      ctrl.sib_scale = ms.scale;
      ctrl.index     = ms.index;
      ctrl.illegal   = word.illegal;
   end

   // the ROM leaves every mux bit clear on an illegal opcode
   always_comb begin
      assert (!(ctrl.illegal && ctrl.mem_wr))
         else $error("operand_decode: memory write on illegal opcode %h", opcode);
   end

endmodule

`default_nettype wire

/* source/ucontrol_store.sv */
`timescale 1ns/100ps
`default_nettype none

module ucontrol_store (
   input  logic [7:0]               opcode,
   input  logic                     two_byte,
   output decode_pkg::ucode_word_t  word
);

   always_comb begin
      word = '0;
      case ({two_byte, opcode})
         // add r/m32,r32 and mov r/m32,r32
         9'h001, 9'h089: begin
            word.data_size       = 2'd2;
            word.mux_seg1_needed = 1'b1;
            word.mux_mem_rd      = 1'b1;
            word.mux_mem_wr      = 1'b1;
            word.mux_ld_gpr1     = 1'b1;
            word.sr1_needed      = (opcode == 8'h01);
            if (opcode == 8'h89) begin
               word.aluk = decode_pkg::aluk_pass;
            end else begin
               word.aluk = decode_pkg::aluk_add;
            end
         end
         // add r32,r/m32 and mov r32,r/m32, always write a gpr
         9'h003, 9'h08B: begin
            word.data_size       = 2'd2;
            word.mux_seg1_needed = 1'b1;
            word.mux_mem_rd      = 1'b1;
            word.ld_gpr1         = 1'b1;
            if (opcode == 8'h8B) begin
               word.aluk = decode_pkg::aluk_pass;
            end else begin
               word.aluk = decode_pkg::aluk_add;
            end
         end
         // add eax,imm32
         9'h005: begin
            word.data_size  = 2'd2;
            word.sr1        = 3'd0;
            word.mux_sr1    = 1'b1;
            word.aluk       = decode_pkg::aluk_add;
            word.ld_gpr1    = 1'b1;
            word.sr1_needed = 1'b1;
         end
         // group 1 with imm32, the operation sits in the reg field
         9'h081: begin
            word.data_size       = 2'd2;
            word.mux_seg1_needed = 1'b1;
            word.mux_aluk        = 1'b1;
            word.mux_mem_rd      = 1'b1;
            word.mux_mem_wr      = 1'b1;
            word.mux_ld_gpr1     = 1'b1;
            word.sr1_needed      = 1'b1;
         end
         // nop
         9'h090: begin
            word.illegal = 1'b0;
         end
         // movq mm,mm/m64
         9'h16F: begin
            word.data_size       = 2'd3;
            word.mux_seg1_needed = 1'b1;
            word.mm1_needed      = 1'b1;
            word.ld_mm           = 1'b1;
         end
         // movq mm/m64,mm
         9'h17F: begin
            word.data_size       = 2'd3;
            word.mux_seg1_needed = 1'b1;
            word.mm1_needed      = 1'b1;
            word.mux_mem_wr      = 1'b1;
         end
         // cmpxchg, byte and dword forms
         9'h1B0, 9'h1B1: begin
            word.data_size       = opcode[0] ? 2'd2 : 2'd0;
            word.mux_seg1_needed = 1'b1;
            word.aluk            = decode_pkg::aluk_cmp;
            word.mux_mem_rd      = 1'b1;
            word.mux_mem_wr      = 1'b1;
            word.sr1_needed      = 1'b1;
         end
         default: begin
            word.illegal = 1'b1;
         end
      endcase
   end

endmodule

`default_nettype wire

/* source/field_selector.sv */
`timescale 1ns/100ps
`default_nettype none

module field_selector #(
   parameter type payload_t = logic [31:0],
   parameter bit  SIGNED    = 1'b0
) (
   input  logic [127:0] ir,
   input  logic [3:0]   sel,
   input  logic [1:0]   size,
   input  logic         present,
   output payload_t     field
);

   localparam int W = $bits(payload_t);

   logic [127:0] window;
   logic [W-1:0] raw;
   logic [2:0]   nbytes;
   logic         sign;

   always_comb begin
      // bring byte sel down to byte 0, bytes past 15 shift in as zero
      window = ir >> {sel, 3'b000};
      case (size)
         decode_pkg::size_byte:  nbytes = 3'd1;
         decode_pkg::size_word:  nbytes = 3'd2;
         decode_pkg::size_dword: nbytes = 3'd4;
         default:                nbytes = 3'd6;
      endcase
      sign = SIGNED && window[8*nbytes-1];
      for (int i = 0; i < W/8; i++) begin
         if (i < nbytes) begin
            raw[8*i +: 8] = window[8*i +: 8];
         end else begin
            raw[8*i +: 8] = {8{sign}};
         end
      end
      if (present) begin
         field = payload_t'(raw);
      end else begin
         field = '0;
      end
   end

   // stage 1 must not mark a field wider than this selector's payload
   always_comb begin
      assert (!present || nbytes <= W/8)
         else $error("field_selector: size code %0d too wide for %0d-bit field", size, W);
   end

endmodule

`default_nettype wire

/* source/decode_pkg.sv */
`default_nettype none

package decode_pkg;

   // segment register ids
   localparam logic [2:0] seg_es = 3'd0;
   localparam logic [2:0] seg_ss = 3'd2;
   localparam logic [2:0] seg_ds = 3'd3;

   // alu function codes carried to execute
   localparam logic [2:0] aluk_add  = 3'd0;
   localparam logic [2:0] aluk_or   = 3'd1;
   localparam logic [2:0] aluk_pass = 3'd5;
   localparam logic [2:0] aluk_cmp  = 3'd7;

   // field size codes, shared by every selector
   localparam logic [1:0] size_byte  = 2'd0;
   localparam logic [1:0] size_word  = 2'd1;
   localparam logic [1:0] size_dword = 2'd2;
   localparam logic [1:0] size_far   = 2'd3;

   // stage-1 packet, fields already located in the window
   typedef struct packed {
      logic [127:0] ir;
      logic [31:0]  eip;
      logic [15:0]  cs;
      logic [15:0]  opcode;
      logic         opcode_size;
      logic         operand_override;
      logic         segment_override;
      logic [2:0]   seg_id;
      logic         modrm_present;
      logic [3:0]   modrm_sel;
      logic         sib_present;
      logic         disp_present;
      logic [3:0]   disp_sel;
      logic [1:0]   disp_size;
      logic         imm_present;
      logic [3:0]   imm_sel;
      logic [1:0]   imm_size;
      logic         offset_present;
      logic [3:0]   offset_sel;
      logic [1:0]   offset_size;
   } d1_packet_t;

   // modrm sits in the low byte, sib in the high byte
   typedef struct packed {
      logic [1:0] scale;
      logic [2:0] index;
      logic [2:0] base;
      logic [1:0] mod;
      logic [2:0] reg_op;
      logic [2:0] rm;
   } modrm_sib_t;

   // microcode control word
   typedef struct packed {
      logic [1:0] data_size;
      logic       seg1_needed;
      logic       mux_seg1_needed;
      logic       mem_rd;
      logic       mux_mem_rd;
      logic       mem_wr;
      logic       mux_mem_wr;
      logic [2:0] aluk;
      logic       mux_aluk;
      logic       ld_gpr1;
      logic       mux_ld_gpr1;
      logic [2:0] sr1;
      logic       mux_sr1;
      logic [2:0] sr2;
      logic       mux_sr2;
      logic       mux_seg2;
      logic       ld_mm;
      logic       mm1_needed;
      logic       sr1_needed;
      logic       illegal;
   } ucode_word_t;

   // controls for address generation and later stages
   typedef struct packed {
      logic [1:0] data_size;
      logic       seg1_needed;
      logic       sr1_needed;
      logic       mm1_needed;
      logic       mem_rd;
      logic       mem_wr;
      logic [2:0] aluk;
      logic       ld_gpr1;
      logic       ld_mm;
      logic [2:0] sr1;
      logic [2:0] sr2;
      logic [2:0] seg1;
      logic [2:0] seg2;
      logic [2:0] base;
      logic [2:0] index;
      logic       sib_en;
      logic       disp_en;
      logic [1:0] sib_scale;
      logic       cmpxchg;
      logic       illegal;
   } ag_ctrl_t;

   typedef struct packed {
      logic [31:0] eip;
      logic [15:0] cs;
      ag_ctrl_t    ctrl;
      logic [31:0] imm32;
      logic [31:0] disp32;
      logic [47:0] offset48;
      logic        illegal;
   } d2_packet_t;

endpackage

`default_nettype wire
